/* Bender.yml */
package:
  name: vec_frontend

export_include_dirs:
  - design

sources:
  - files:
      - design/vec_frontend_pkg.sv
      - design/vec_issue_reg.sv
      - design/vec_decoder.sv
      - design/vec_config_commit.sv
      - design/vec_fifo.sv
      - design/vec_frontend.sv
  - target: test
    files:
      - dv/tb_vec_frontend.sv

/* design/vec_config_commit.sv */
////////////////////////////////////////////////////////////
// Vector configuration and commit unit
// Holds vl, vtype and vstart and feeds both output queues
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_frontend_params.svh"

module vec_config_commit (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  vec_frontend_pkg::decoded_t  dec_i,
  input  wire logic                   held_valid_i,
  output logic                        take_o,
  output vec_frontend_pkg::core_rsp_t rsp_o,
  output logic                        rsp_push_o,
  input  wire logic                   rsp_space_i,
  output vec_frontend_pkg::vec_req_t  disp_o,
  output logic                        disp_push_o,
  input  wire logic                   disp_space_i
);

  import vec_frontend_pkg::*;

  localparam elen_t vlen = elen_t'(`VEC_VLEN);

  elen_t  vl_q;
  elen_t  vstart_q;
  vtype_t vtype_q;

  logic   is_illegal;
  logic   needs_disp;
  logic   cfg_legal;
  elen_t  vlmax;
  elen_t  avl;
  elen_t  new_vl;
  elen_t  csr_rdata;

  // Arithmetic needs a valid vtype
  assign is_illegal = dec_i.illegal || (dec_i.ex_unit == VFU && vtype_q.vill);
  assign needs_disp = !is_illegal && dec_i.ex_unit != CON;
  assign take_o     = held_valid_i && rsp_space_i && (disp_space_i || !needs_disp);

  // SEW 8..32 and integer LMUL only
  assign cfg_legal = !dec_i.vtype.vill && dec_i.vtype.vsew <= 3'd2 && !dec_i.vtype.vlmul[2];
  assign vlmax     = (vlen >> (3 + dec_i.vtype.vsew)) << dec_i.vtype.vlmul[1:0];

  always_comb begin
    if (dec_i.cfg_kind == CFG_VSETIVLI) begin
      avl = elen_t'(dec_i.avl_field);
    end else if (dec_i.avl_field != 5'd0) begin
      avl = dec_i.scalar;
    end else if (dec_i.rd != 5'd0) begin
      avl = vlmax;
    end else begin
      avl = vl_q;
    end
  end

  assign new_vl = !cfg_legal ? '0 : (avl < vlmax) ? avl : vlmax;

  always_comb begin
    unique case (dec_i.csr_addr)
      CsrVstart: csr_rdata = vstart_q;
      CsrVl:     csr_rdata = vl_q;
      CsrVtype:  csr_rdata = {vtype_q.vill, {(ELEN-9){1'b0}}, vtype_q[7:0]};
      CsrVlenb:  csr_rdata = vlen >> 3;
      default:   csr_rdata = '0;
    endcase
  end

  assign rsp_push_o     = take_o;
  assign rsp_o.rd       = dec_i.rd;
  assign rsp_o.illegal  = is_illegal;
  assign rsp_o.write_rd = !is_illegal && dec_i.ex_unit == CON;
  assign rsp_o.data     = !rsp_o.write_rd ? '0 : (dec_i.op == VCFG) ? new_vl : csr_rdata;

  assign disp_push_o      = take_o && needs_disp;
  assign disp_o.op        = dec_i.op;
  assign disp_o.ex_unit   = dec_i.ex_unit;
  assign disp_o.vd        = dec_i.vd;
  assign disp_o.vs1       = dec_i.vs1;
  assign disp_o.vs2       = dec_i.vs2;
  assign disp_o.use_vs1   = dec_i.use_vs1;
  assign disp_o.vm        = dec_i.vm;
  assign disp_o.vd_is_src = dec_i.vd_is_src;
  assign disp_o.scalar    = dec_i.scalar;
  assign disp_o.vl        = vl_q;
  assign disp_o.sew       = vtype_q.vsew;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vl_q     <= '0;
      vstart_q <= '0;
      vtype_q  <= '{vill: 1'b1, default: '0};
    end else if (take_o && !is_illegal) begin
      if (dec_i.op == VCFG) begin
        vl_q     <= new_vl;
        vtype_q  <= cfg_legal ? dec_i.vtype : '{vill: 1'b1, default: '0};
        vstart_q <= '0;
      end else if (dec_i.op == VCSR) begin
        if (dec_i.csr_write) begin
          vstart_q <= dec_i.scalar;
        end
      end else begin
        vstart_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/vec_decoder.sv */
////////////////////////////////////////////////////////////
// Vector instruction decoder
// Classifies config, CSR, unit-stride memory and integer ops
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_decoder (
  input  vec_frontend_pkg::core_req_t req_i,
  output vec_frontend_pkg::decoded_t  dec_o
);

  import vec_frontend_pkg::*;

  logic [6:0] opcode;
  logic [4:0] rd_f;
  logic [4:0] rs1_f;
  logic [4:0] rs2_f;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic       is_opi;
  logic       is_opm;
  elen_t      vtype_raw;

  assign opcode = req_i.instr[6:0];
  assign rd_f   = req_i.instr[11:7];
  assign funct3 = req_i.instr[14:12];
  assign rs1_f  = req_i.instr[19:15];
  assign rs2_f  = req_i.instr[24:20];
  assign funct6 = req_i.instr[31:26];
  assign is_opi = funct3 inside {OPIVV, OPIVI, OPIVX};
  assign is_opm = funct3 inside {OPMVV, OPMVX};

  always_comb begin
    dec_o           = '0;
    vtype_raw       = '0;
    dec_o.ex_unit   = CON;
    dec_o.rd        = rd_f;
    dec_o.vd        = rd_f;
    dec_o.vs2       = rs2_f;
    dec_o.vm        = req_i.instr[25];
    dec_o.avl_field = rs1_f;
    dec_o.scalar    = req_i.rs1;

    unique case (opcode)
      OpcodeLoadFP,
      OpcodeStoreFP: begin
        dec_o.op      = (opcode == OpcodeLoadFP) ? VLE : VSE;
        dec_o.ex_unit = LSU;
        // nf, mew, mop and lumop all zero for plain unit stride
        if (funct6 != 6'b000000 || rs2_f != 5'd0) begin
          dec_o.illegal = 1'b1;
        end
        if (!(funct3 inside {3'b000, 3'b101, 3'b110})) begin
          dec_o.illegal = 1'b1;
        end
      end

      OpcodeVec: begin
        if (funct3 == OPCFG) begin
          dec_o.op = VCFG;
          if (!req_i.instr[31]) begin
            dec_o.cfg_kind = CFG_VSETVLI;
            vtype_raw      = elen_t'(req_i.instr[30:20]);
          end else if (req_i.instr[30]) begin
            dec_o.cfg_kind = CFG_VSETIVLI;
            vtype_raw      = elen_t'(req_i.instr[29:20]);
          end else if (req_i.instr[29:25] == 5'b00000) begin
            dec_o.cfg_kind = CFG_VSETVL;
            vtype_raw      = req_i.rs2;
          end else begin
            dec_o.illegal = 1'b1;
          end
          // Any reserved bit set means vill
          dec_o.vtype = {|vtype_raw[ELEN-1:8], vtype_raw[7:0]};
        end else begin
          dec_o.ex_unit = VFU;
          unique case (funct3)
            OPIVV, OPMVV: begin
              dec_o.use_vs1 = 1'b1;
              dec_o.vs1     = rs1_f;
            end
            OPIVI:        dec_o.scalar = elen_t'($signed(rs1_f));
            OPIVX, OPMVX: dec_o.scalar = req_i.rs1;
            default:      dec_o.illegal = 1'b1;
          endcase

          if (is_opi) begin
            unique case (funct6)
              6'b000000: dec_o.op = VADD;
              6'b000010: dec_o.op = VSUB;
              6'b000011: dec_o.op = VRSUB;
              6'b000101: dec_o.op = VMIN;
              6'b000111: dec_o.op = VMAX;
              6'b001001: dec_o.op = VAND;
              6'b001010: dec_o.op = VOR;
              6'b001011: dec_o.op = VXOR;
              6'b100101: dec_o.op = VSLL;
              6'b101000: dec_o.op = VSRL;
              6'b101001: dec_o.op = VSRA;
              default:   dec_o.illegal = 1'b1;
            endcase
          end else if (is_opm) begin
            unique case (funct6)
              6'b100101: dec_o.op = VMUL;
              6'b101101: begin
                dec_o.op        = VMACC;
                dec_o.vd_is_src = 1'b1;
              end
              default:   dec_o.illegal = 1'b1;
            endcase
          end

          // Forms missing from the spec
          if ((dec_o.op inside {VSUB, VMIN, VMAX} && funct3 == OPIVI) ||
              (dec_o.op == VRSUB && funct3 == OPIVV)) begin
            dec_o.illegal = 1'b1;
          end
        end
      end

      OpcodeSystem: begin
        dec_o.op        = VCSR;
        dec_o.csr_addr  = req_i.instr[31:20];
        dec_o.csr_write = (funct3 == F3Csrrw);
        if (!(dec_o.csr_addr inside {CsrVstart, CsrVl, CsrVtype, CsrVlenb})) begin
          dec_o.illegal = 1'b1;
        end
        // Only vstart takes a write, and csrrs must not set bits
        if (funct3 == F3Csrrw) begin
          dec_o.illegal |= (dec_o.csr_addr != CsrVstart);
        end else if (funct3 == F3Csrrs) begin
          dec_o.illegal |= (rs1_f != 5'd0);
        end else begin
          dec_o.illegal = 1'b1;
        end
      end

      default: dec_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* design/vec_fifo.sv */
////////////////////////////////////////////////////////////
// Synchronous FIFO for any packed payload
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_frontend_params.svh"

module vec_fifo #(
  parameter type payload_t = logic [31:0]
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic push_i,
  input  payload_t  data_i,
  output logic      space_o,
  output payload_t  data_o,
  output logic      valid_o,
  input  wire logic ready_i
);

  localparam int unsigned depth = `VEC_FIFO_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  payload_t           mem_q [depth];
  logic [ptr_w-1:0]   wr_ptr_q;
  logic [ptr_w-1:0]   rd_ptr_q;
  logic [cnt_w-1:0]   count_q;
  logic               do_push;
  logic               do_pop;

  assign valid_o = (count_q != '0);
  assign do_pop  = valid_o && ready_i;
  // Pop frees a slot for this cycle's push
  assign space_o = (count_q != cnt_w'(depth)) || do_pop;
  assign do_push = push_i && space_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + cnt_w'(do_push) - cnt_w'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* design/vec_frontend.sv */
////////////////////////////////////////////////////////////
// Vector unit front end
// Issue, decode and commit with dispatch and response queues
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_frontend (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  // Core request
  input  vec_frontend_pkg::core_req_t core_req_i,
  input  wire logic                   core_req_valid_i,
  output logic                        core_req_ready_o,
  // Core response, in order
  output vec_frontend_pkg::core_rsp_t core_rsp_o,
  output logic                        core_rsp_valid_o,
  input  wire logic                   core_rsp_ready_i,
  // Toward the execution units
  output vec_frontend_pkg::vec_req_t  vec_req_o,
  output logic                        vec_req_valid_o,
  input  wire logic                   vec_req_ready_i
);

  import vec_frontend_pkg::*;

  core_req_t held;
  logic      held_valid;
  logic      take;
  decoded_t  dec;
  core_rsp_t rsp;
  logic      rsp_push;
  logic      rsp_space;
  vec_req_t  disp;
  logic      disp_push;
  logic      disp_space;

  vec_issue_reg issue_reg (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (core_req_i),
    .req_valid_i  (core_req_valid_i),
    .req_ready_o  (core_req_ready_o),
    .held_o       (held),
    .held_valid_o (held_valid),
    .take_i       (take)
  );

  vec_decoder decoder (
    .req_i (held),
    .dec_o (dec)
  );

  vec_config_commit config_commit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .dec_i        (dec),
    .held_valid_i (held_valid),
    .take_o       (take),
    .rsp_o        (rsp),
    .rsp_push_o   (rsp_push),
    .rsp_space_i  (rsp_space),
    .disp_o       (disp),
    .disp_push_o  (disp_push),
    .disp_space_i (disp_space)
  );

  vec_fifo #(.payload_t(core_rsp_t)) rsp_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rsp_push),
    .data_i  (rsp),
    .space_o (rsp_space),
    .data_o  (core_rsp_o),
    .valid_o (core_rsp_valid_o),
    .ready_i (core_rsp_ready_i)
  );

  vec_fifo #(.payload_t(vec_req_t)) disp_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (disp_push),
    .data_i  (disp),
    .space_o (disp_space),
    .data_o  (vec_req_o),
    .valid_o (vec_req_valid_o),
    .ready_i (vec_req_ready_i)
  );

endmodule

`default_nettype wire

/* design/vec_frontend_params.svh */
////////////////////////////////////////////////////////////
// Vector front end sizing
// Register length, element width and queue depth
////////////////////////////////////////////////////////////

`ifndef VEC_FRONTEND_PARAMS_SVH
`define VEC_FRONTEND_PARAMS_SVH

// Vector register length in bits
`define VEC_VLEN 256

// Scalar operand and widest element width
`define VEC_ELEN 32

// Entries in each output queue
`define VEC_FIFO_DEPTH 4

`endif

/* design/vec_frontend_pkg.sv */
////////////////////////////////////////////////////////////
// Vector front end types
// Encodings, CSR addresses and the payloads between blocks
////////////////////////////////////////////////////////////

`default_nettype none

package vec_frontend_pkg;

`include "vec_frontend_params.svh"

  localparam int unsigned ELEN = `VEC_ELEN;
  typedef logic [ELEN-1:0] elen_t;

  // Major opcodes
  localparam logic [6:0] OpcodeVec     = 7'b1010111;
  localparam logic [6:0] OpcodeLoadFP  = 7'b0000111;
  localparam logic [6:0] OpcodeStoreFP = 7'b0100111;
  localparam logic [6:0] OpcodeSystem  = 7'b1110011;

  // Vector funct3 categories
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPFVV = 3'b001;
  localparam logic [2:0] OPMVV = 3'b010;
  localparam logic [2:0] OPIVI = 3'b011;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPFVF = 3'b101;
  localparam logic [2:0] OPMVX = 3'b110;
  localparam logic [2:0] OPCFG = 3'b111;

  // Zicsr funct3
  localparam logic [2:0] F3Csrrw = 3'b001;
  localparam logic [2:0] F3Csrrs = 3'b010;

  localparam logic [11:0] CsrVstart = 12'h008;
  localparam logic [11:0] CsrVl     = 12'hc20;
  localparam logic [11:0] CsrVtype  = 12'hc21;
  localparam logic [11:0] CsrVlenb  = 12'hc22;

  typedef enum logic [1:0] {CON, VFU, LSU} ex_unit_e;

  typedef enum logic [4:0] {
    VADD, VSUB, VRSUB, VAND, VOR, VXOR, VSLL, VSRL, VSRA,
    VMIN, VMAX, VMUL, VMACC, VLE, VSE, VCFG, VCSR
  } vec_op_e;

  typedef enum logic [1:0] {CFG_VSETVLI, CFG_VSETIVLI, CFG_VSETVL} cfg_kind_e;

  // Low byte follows the vtype CSR layout
  typedef struct packed {
    logic       vill;
    logic       vma;
    logic       vta;
    logic [2:0] vsew;
    logic [2:0] vlmul;
  } vtype_t;

  typedef struct packed {
    logic [31:0] instr;
    elen_t       rs1;
    elen_t       rs2;
  } core_req_t;

  typedef struct packed {
    vec_op_e    op;
    ex_unit_e   ex_unit;
    logic [4:0] vd;
    logic [4:0] vs1;
    logic [4:0] vs2;
    logic       use_vs1;
    logic       vm;
    logic       vd_is_src;
    elen_t      scalar;
    cfg_kind_e  cfg_kind;
    vtype_t     vtype;
    logic [4:0] avl_field;
    logic [4:0] rd;
    logic [11:0] csr_addr;
    logic       csr_write;
    logic       illegal;
  } decoded_t;

  typedef struct packed {
    vec_op_e    op;
    ex_unit_e   ex_unit;
    logic [4:0] vd;
    logic [4:0] vs1;
    logic [4:0] vs2;
    logic       use_vs1;
    logic       vm;
    logic       vd_is_src;
    elen_t      scalar;
    elen_t      vl;
    logic [2:0] sew;
  } vec_req_t;

  typedef struct packed {
    logic [4:0] rd;
    elen_t      data;
    logic       write_rd;
    logic       illegal;
  } core_rsp_t;

endpackage

`default_nettype wire

/* design/vec_issue_reg.sv */
////////////////////////////////////////////////////////////
// Vector issue register
// Holds one core request until the commit unit takes it
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_issue_reg (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  // Core side
  input  vec_frontend_pkg::core_req_t      req_i,
  input  wire logic                        req_valid_i,
  output logic                             req_ready_o,
  // Commit side
  output vec_frontend_pkg::core_req_t      held_o,
  output logic                             held_valid_o,
  input  wire logic                        take_i
);

  vec_frontend_pkg::core_req_t held_q;
  logic                        valid_q;

  // Empty, or drained this cycle
  assign req_ready_o = !valid_q || take_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      held_q <= req_i;
    end
  end

  assign held_o       = held_q;
  assign held_valid_o = valid_q;

endmodule

`default_nettype wire

/* dv/tb_vec_frontend.sv */
////////////////////////////////////////////////////////////
// Vector front end testbench
// Directed tests checked against a model of vl, vtype, vstart
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_frontend_params.svh"

module tb_vec_frontend;

  import vec_frontend_pkg::*;

  localparam int unsigned vlen  = `VEC_VLEN;
  localparam int unsigned depth = `VEC_FIFO_DEPTH;
  // Around 120 instructions at one per cycle plus drain gaps
  localparam int unsigned max_cycles = 4000;

  localparam int form_vv = 0;
  localparam int form_vx = 1;
  localparam int form_vi = 2;

  logic      clk;
  logic      rst;
  core_req_t core_req;
  logic      core_req_valid;
  logic      core_req_ready;
  core_rsp_t core_rsp;
  logic      core_rsp_valid;
  logic      core_rsp_ready;
  vec_req_t  vec_req;
  logic      vec_req_valid;
  logic      vec_req_ready;

  // Model state
  logic [31:0] model_vl;
  logic [31:0] model_vtype;
  logic [31:0] model_vstart;

  core_rsp_t exp_rsp [$];
  vec_req_t  exp_disp [$];
  core_rsp_t want_rsp;
  vec_req_t  want_disp;

  int unsigned cycle_cnt    = 0;
  int unsigned error_cnt    = 0;
  int unsigned test_cnt     = 0;
  int unsigned fail_cnt     = 0;
  int unsigned accepted_cnt = 0;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  vec_frontend vec_frontend_i (
    .clk_i            (clk),
    .rst_i            (rst),
    .core_req_i       (core_req),
    .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready),
    .core_rsp_o       (core_rsp),
    .core_rsp_valid_o (core_rsp_valid),
    .core_rsp_ready_i (core_rsp_ready),
    .vec_req_o        (vec_req),
    .vec_req_valid_o  (vec_req_valid),
    .vec_req_ready_i  (vec_req_ready)
  );

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output monitors
  ////////////////////////////////////////////////////////////

  // Sampled mid-cycle, the transfer completes at the next edge
  always @(negedge clk) begin
    if (!rst && core_rsp_valid && core_rsp_ready) begin
      if (exp_rsp.size() == 0) begin
        $display("Response for rd %0d arrived with none expected", core_rsp.rd);
        error_cnt++;
      end else begin
        want_rsp = exp_rsp.pop_front();
        if (core_rsp !== want_rsp) begin
          $display("[ERROR] core_rsp_o: got %h, expected %h", core_rsp, want_rsp);
          error_cnt++;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && vec_req_valid && vec_req_ready) begin
      if (exp_disp.size() == 0) begin
        $display("Dispatch of %s arrived with none expected", vec_req.op.name());
        error_cnt++;
      end else begin
        want_disp = exp_disp.pop_front();
        if (vec_req !== want_disp) begin
          $display("[ERROR] vec_req_o: got %h, expected %h", vec_req, want_disp);
          error_cnt++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] vlmax_of(input logic [31:0] vt);
    return (vlen / (8 << vt[5:3])) << vt[1:0];
  endfunction

  // SEW 8, 16 or 32, integer LMUL, no reserved bits
  function automatic logic vtype_ok(input logic [31:0] vt);
    return vt[31:8] == '0 && vt[5:3] <= 3'd2 && !vt[2];
  endfunction

  function automatic logic [5:0] funct6_of(input vec_op_e op);
    case (op)
      VADD:    return 6'b000000;
      VSUB:    return 6'b000010;
      VRSUB:   return 6'b000011;
      VAND:    return 6'b001001;
      VOR:     return 6'b001010;
      VXOR:    return 6'b001011;
      VSLL:    return 6'b100101;
      VSRL:    return 6'b101000;
      VSRA:    return 6'b101001;
      VMIN:    return 6'b000101;
      VMAX:    return 6'b000111;
      VMUL:    return 6'b100101;
      VMACC:   return 6'b101101;
      default: return 6'b111111;
    endcase
  endfunction

  // Forms that exist in the vector spec
  function automatic logic form_ok(input vec_op_e op, input int form);
    if (form == form_vi) begin
      return !(op inside {VSUB, VMIN, VMAX, VMUL, VMACC});
    end
    return !(form == form_vv && op == VRSUB);
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic send_req(input logic [31:0] instr, input logic [31:0] rs1,
                          input logic [31:0] rs2);
    core_req.instr = instr;
    core_req.rs1   = rs1;
    core_req.rs2   = rs2;
    core_req_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!core_req_ready);
    @(posedge clk);
    #1;
    core_req_valid = 1'b0;
    accepted_cnt++;
  endtask

  // kind 0 vsetvli, 1 vsetivli, 2 vsetvl
  task automatic apply_vset(input int kind, input logic [4:0] rd, input logic [4:0] avl_field,
                            input logic [31:0] avl_val, input logic [31:0] vt_in);
    logic [31:0] instr;
    logic [31:0] vt;
    logic [31:0] vlmax;
    logic [31:0] avl;
    logic [31:0] new_vl;
    logic [4:0]  rs2_f;
    core_rsp_t   rsp;
    rs2_f = 5'($urandom_range(1, 31));
    if (kind == 0) begin
      vt    = {21'd0, vt_in[10:0]};
      instr = {1'b0, vt[10:0], avl_field, OPCFG, rd, OpcodeVec};
    end else if (kind == 1) begin
      vt    = {22'd0, vt_in[9:0]};
      instr = {2'b11, vt[9:0], avl_field, OPCFG, rd, OpcodeVec};
    end else begin
      vt    = vt_in;
      instr = {7'b1000000, rs2_f, avl_field, OPCFG, rd, OpcodeVec};
    end
    vlmax = vlmax_of(vt);
    if (kind == 1) begin
      avl = 32'(avl_field);
    end else if (avl_field != 5'd0) begin
      avl = avl_val;
    end else if (rd != 5'd0) begin
      avl = vlmax;
    end else begin
      avl = model_vl;
    end
    new_vl = !vtype_ok(vt) ? 32'd0 : (avl < vlmax) ? avl : vlmax;
    rsp          = '0;
    rsp.rd       = rd;
    rsp.data     = new_vl;
    rsp.write_rd = 1'b1;
    exp_rsp.push_back(rsp);
    model_vl     = new_vl;
    model_vtype  = vtype_ok(vt) ? vt : 32'h8000_0000;
    model_vstart = '0;
    send_req(instr, avl_val, vt);
  endtask

  task automatic access_csr(input logic write, input logic [4:0] rd, input logic [11:0] addr,
                            input logic [31:0] wdata);
    logic [4:0] rs1_f;
    core_rsp_t  rsp;
    rs1_f  = write ? 5'($urandom_range(1, 31)) : 5'd0;
    rsp    = '0;
    rsp.rd = rd;
    if (!(addr inside {CsrVstart, CsrVl, CsrVtype, CsrVlenb}) ||
        (write && addr != CsrVstart)) begin
      rsp.illegal = 1'b1;
    end else begin
      rsp.write_rd = 1'b1;
      case (addr)
        CsrVstart: rsp.data = model_vstart;
        CsrVl:     rsp.data = model_vl;
        CsrVtype:  rsp.data = model_vtype;
        default:   rsp.data = vlen / 8;
      endcase
      if (write) begin
        model_vstart = wdata;
      end
    end
    exp_rsp.push_back(rsp);
    send_req({addr, rs1_f, write ? F3Csrrw : F3Csrrs, rd, OpcodeSystem}, wdata, 32'h0);
  endtask

  task automatic issue_arith(input vec_op_e op, input int form, input logic [4:0] vd,
                             input logic [4:0] vs2, input logic [4:0] src,
                             input logic [31:0] rs1, input logic vm);
    logic       opm;
    logic [2:0] f3;
    core_rsp_t  rsp;
    vec_req_t   req;
    opm = op inside {VMUL, VMACC};
    case (form)
      form_vv: f3 = opm ? OPMVV : OPIVV;
      form_vx: f3 = opm ? OPMVX : OPIVX;
      default: f3 = OPIVI;
    endcase
    rsp    = '0;
    rsp.rd = vd;
    // No arithmetic while vtype is invalid
    if (model_vtype[31]) begin
      rsp.illegal = 1'b1;
    end else begin
      req           = '0;
      req.op        = op;
      req.ex_unit   = VFU;
      req.vd        = vd;
      req.vs1       = (form == form_vv) ? src : 5'd0;
      req.vs2       = vs2;
      req.use_vs1   = (form == form_vv);
      req.vm        = vm;
      req.vd_is_src = (op == VMACC);
      req.scalar    = (form == form_vi) ? {{27{src[4]}}, src} : rs1;
      req.vl        = model_vl;
      req.sew       = model_vtype[5:3];
      exp_disp.push_back(req);
      model_vstart = '0;
    end
    exp_rsp.push_back(rsp);
    send_req({funct6_of(op), vm, vs2, src, f3, vd, OpcodeVec}, rs1, 32'h0);
  endtask

  task automatic mem_access(input logic store, input logic [4:0] vd, input logic vm,
                            input logic [31:0] base);
    logic [4:0] rs1_f;
    core_rsp_t  rsp;
    vec_req_t   req;
    rs1_f       = 5'($urandom_range(1, 31));
    rsp         = '0;
    rsp.rd      = vd;
    req         = '0;
    req.op      = store ? VSE : VLE;
    req.ex_unit = LSU;
    req.vd      = vd;
    req.vm      = vm;
    req.scalar  = base;
    req.vl      = model_vl;
    req.sew     = model_vtype[5:3];
    exp_rsp.push_back(rsp);
    exp_disp.push_back(req);
    model_vstart = '0;
    // Unit stride, one field, 32-bit elements
    send_req({3'b000, 1'b0, 2'b00, vm, 5'b00000, rs1_f, 3'b110, vd,
              store ? OpcodeStoreFP : OpcodeLoadFP}, base, 32'h0);
  endtask

  task automatic reject_instr(input logic [31:0] instr);
    core_rsp_t rsp;
    rsp         = '0;
    rsp.rd      = instr[11:7];
    rsp.illegal = 1'b1;
    exp_rsp.push_back(rsp);
    send_req(instr, $urandom, $urandom);
  endtask

  task automatic wait_drain();
    while (exp_rsp.size() != 0 || exp_disp.size() != 0) begin
      @(posedge clk);
    end
    // Leave room for a stray extra entry to show up
    repeat (3) @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name, input int unsigned start);
    test_cnt++;
    wait_drain();
    if (error_cnt == start) begin
      $display("test %-18s ok", name);
    end else begin
      fail_cnt++;
      $display("test %-18s failed with %0d errors", name, error_cnt - start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state();
    int unsigned start;
    start = error_cnt;
    if (core_req_ready !== 1'b1) begin
      $display("[ERROR] core_req_ready_o: got %h, expected %h", core_req_ready, 1'b1);
      error_cnt++;
    end
    if (core_rsp_valid !== 1'b0) begin
      $display("[ERROR] core_rsp_valid_o: got %h, expected %h", core_rsp_valid, 1'b0);
      error_cnt++;
    end
    if (vec_req_valid !== 1'b0) begin
      $display("[ERROR] vec_req_valid_o: got %h, expected %h", vec_req_valid, 1'b0);
      error_cnt++;
    end
    // vill set and vl zero out of reset
    access_csr(1'b0, 5'd1, CsrVtype, 32'h0);
    access_csr(1'b0, 5'd2, CsrVl, 32'h0);
    report_test("reset state", start);
  endtask

  task automatic vset_forms();
    int unsigned start;
    logic [31:0] vt;
    start = error_cnt;
    for (int sew = 0; sew < 3; sew++) begin
      for (int lmul = 0; lmul < 4; lmul++) begin
        vt = {24'd0, 2'($urandom_range(0, 3)), 3'(sew), 3'(lmul)};
        apply_vset(0, 5'($urandom_range(1, 31)), 5'($urandom_range(1, 31)),
                   $urandom_range(0, 300), vt);
        apply_vset(1, 5'($urandom_range(1, 31)), 5'($urandom_range(0, 31)), 32'h0, vt);
        apply_vset(2, 5'($urandom_range(1, 31)), 5'($urandom_range(1, 31)),
                   $urandom_range(0, 300), vt);
      end
    end
    // SEW 16, LMUL 4 with zero rs1 field
    apply_vset(0, 5'd3, 5'd0, 32'd5, 32'h0a);
    apply_vset(0, 5'd3, 5'd4, 32'd20, 32'h0a);
    apply_vset(0, 5'd0, 5'd0, 32'd5, 32'h0a);
    apply_vset(2, 5'd0, 5'd0, 32'd9, 32'h0a);
    // LMUL 1/2 is not supported
    apply_vset(0, 5'd7, 5'd2, 32'd16, 32'h07);
    access_csr(1'b0, 5'd8, CsrVtype, 32'h0);
    access_csr(1'b0, 5'd9, CsrVl, 32'h0);
    report_test("vset forms", start);
  endtask

  task automatic csr_access();
    int unsigned start;
    logic [31:0] wval;
    start = error_cnt;
    wval  = $urandom_range(1, 255);
    apply_vset(1, 5'd1, 5'd13, 32'h0, 32'h09);
    access_csr(1'b0, 5'd10, CsrVl, 32'h0);
    access_csr(1'b0, 5'd11, CsrVtype, 32'h0);
    access_csr(1'b0, 5'd12, CsrVlenb, 32'h0);
    access_csr(1'b0, 5'd13, CsrVstart, 32'h0);
    access_csr(1'b1, 5'd14, CsrVstart, wval);
    access_csr(1'b1, 5'd15, CsrVstart, wval + 1);
    access_csr(1'b0, 5'd16, CsrVstart, 32'h0);
    report_test("csr access", start);
  endtask

  task automatic arith_dispatch();
    int unsigned start;
    vec_op_e     op;
    start = error_cnt;
    apply_vset(0, 5'd1, 5'd1, 32'd200, 32'h12);
    access_csr(1'b1, 5'd2, CsrVstart, 32'd5);
    for (int i = 0; i <= int'(VMACC); i++) begin
      op = vec_op_e'(i);
      for (int form = form_vv; form <= form_vi; form++) begin
        if (form_ok(op, form)) begin
          issue_arith(op, form, 5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)),
                      5'($urandom_range(0, 31)), (form == form_vx) ? $urandom : 32'h0,
                      1'($urandom_range(0, 1)));
        end
      end
    end
    access_csr(1'b0, 5'd3, CsrVstart, 32'h0);
    report_test("arith dispatch", start);
  endtask

  task automatic mem_dispatch();
    int unsigned start;
    start = error_cnt;
    apply_vset(1, 5'd4, 5'd20, 32'h0, 32'h08);
    mem_access(1'b0, 5'($urandom_range(0, 31)), 1'b1, $urandom);
    mem_access(1'b1, 5'($urandom_range(0, 31)), 1'b0, $urandom);
    report_test("mem dispatch", start);
  endtask

  task automatic illegal_instrs();
    int unsigned start;
    start = error_cnt;
    apply_vset(0, 5'd5, 5'd6, 32'd11, 32'h00);
    // Floating point VV form
    reject_instr({6'b000000, 1'b1, 5'd2, 5'd3, OPFVV, 5'd4, OpcodeVec});
    // funct6 with no integer operation
    reject_instr({6'b111111, 1'b1, 5'd2, 5'd3, OPIVV, 5'd4, OpcodeVec});
    access_csr(1'b0, 5'd6, 12'h123, 32'h0);
    // Scalar OP major opcode
    reject_instr({7'b0000000, 5'd2, 5'd3, 3'b000, 5'd4, 7'b0110011});
    access_csr(1'b0, 5'd7, CsrVl, 32'h0);
    apply_vset(0, 5'd8, 5'd6, 32'd11, 32'h07);
    issue_arith(VADD, form_vv, 5'd1, 5'd2, 5'd3, 32'h0, 1'b1);
    access_csr(1'b0, 5'd9, CsrVl, 32'h0);
    report_test("illegal instrs", start);
  endtask

  task automatic back_pressure();
    int unsigned start;
    int unsigned base;
    start = error_cnt;
    apply_vset(0, 5'd9, 5'd1, 32'd100, 32'h11);
    wait_drain();
    vec_req_ready = 1'b0;
    base          = accepted_cnt;
    fork
      begin
        for (int i = 0; i < 10; i++) begin
          issue_arith(vec_op_e'(i), form_vx, 5'(i + 1), 5'(i + 11), 5'd0, 32'(i * 3), 1'b1);
        end
      end
      begin
        do begin
          @(negedge clk);
        end while (!(core_req_valid && !core_req_ready));
        // Dispatch queue full plus one held in the issue register
        if (accepted_cnt - base != depth + 1) begin
          $display("Request stall came after %0d accepted instructions, not %0d",
                   accepted_cnt - base, depth + 1);
          error_cnt++;
        end
        repeat (5) @(posedge clk);
        #1;
        vec_req_ready = 1'b1;
      end
    join
    report_test("back pressure", start);
  endtask

  initial begin
    void'($urandom(32'hc93de24b));
    rst            = 1'b1;
    core_req       = '0;
    core_req_valid = 1'b0;
    core_rsp_ready = 1'b1;
    vec_req_ready  = 1'b1;
    model_vl       = '0;
    model_vstart   = '0;
    model_vtype    = 32'h8000_0000;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    reset_state();
    vset_forms();
    csr_access();
    arith_dispatch();
    mem_dispatch();
    illegal_instrs();
    back_pressure();

    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             test_cnt, test_cnt - fail_cnt, fail_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vec_frontend.f */
+incdir+design
design/vec_frontend_pkg.sv
design/vec_issue_reg.sv
design/vec_decoder.sv
design/vec_config_commit.sv
design/vec_fifo.sv
design/vec_frontend.sv
dv/tb_vec_frontend.sv
